// File: hdl/xm_types_pkg.sv
// shared data types and timer divider constants for the host register window
`default_nettype none

package xm_types_pkg;

    typedef logic [15:0] word_t;       // register and memory word
    typedef logic [15:0] addr_t;       // memory address
    typedef logic [7:0]  byte_t;       // host bus byte
    typedef logic [3:0]  reg_num_t;    // host register number

    // channel register targeted by a byte write
    typedef enum logic [2:0] {
        RD_INCR,
        RD_ADDR,
        WR_INCR,
        WR_ADDR,
        DATA
    } chan_field_t;

    // 10 kHz / 25.125 MHz reduces to 2 / 5025
    localparam int CLK_REDUCED = 5025;
    localparam int HZ_REDUCED  = 2;

    // top bit is the sign of the fraction accumulator
    localparam int FRAC_BITS   = $clog2(CLK_REDUCED) + 1;

endpackage

`default_nettype wire

// File: hdl/xm_regmap_pkg.sv
// register numbers and status bit positions of the host register window
`default_nettype none

package xm_regmap_pkg;

    // register 1 is unused and reads zero
    localparam xm_types_pkg::reg_num_t XM_SYS_CTRL = 4'h0;    // status and write mask
    localparam xm_types_pkg::reg_num_t XM_TIMER    = 4'h2;    // 1/10 ms timer
    localparam xm_types_pkg::reg_num_t XM_RD_XADDR = 4'h3;    // XR read address
    localparam xm_types_pkg::reg_num_t XM_WR_XADDR = 4'h4;    // XR write address
    localparam xm_types_pkg::reg_num_t XM_XDATA    = 4'h5;    // XR data
    localparam xm_types_pkg::reg_num_t XM_RD_INCR  = 4'h6;    // VRAM read increment
    localparam xm_types_pkg::reg_num_t XM_RD_ADDR  = 4'h7;    // VRAM read address
    localparam xm_types_pkg::reg_num_t XM_WR_INCR  = 4'h8;    // VRAM write increment
    localparam xm_types_pkg::reg_num_t XM_WR_ADDR  = 4'h9;    // VRAM write address
    localparam xm_types_pkg::reg_num_t XM_DATA     = 4'hA;    // VRAM data
    localparam xm_types_pkg::reg_num_t XM_DATA_2   = 4'hB;    // VRAM data, second port

    // SYS_CTRL layout, mask in bits 3..0
    localparam int SYS_MEM_WAIT_BIT = 15;
    localparam int SYS_HBLANK_BIT   = 11;
    localparam int SYS_VBLANK_BIT   = 10;

    localparam logic [3:0] WRMASK_RESET = 4'b1111;    // all nibbles writable

endpackage

`default_nettype wire

// File: hdl/xm_bus_sync.sv
// CPU bus synchronizer, turns chip select falling edges into byte strobes
`default_nettype none

module xm_bus_sync (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_cs_n_i,       // async chip select
    input  wire logic                   bus_rd_nwr_i,     // 1 = read
    input  wire xm_types_pkg::reg_num_t bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,    // 0 = even (high) byte
    input  wire xm_types_pkg::byte_t    bus_data_i,
    output logic                        write_strobe_o,
    output logic                        read_strobe_o,
    output xm_types_pkg::reg_num_t      reg_num_o,
    output logic                        bytesel_o,
    output xm_types_pkg::byte_t         byte_o
);

    logic                   cs_n_meta;
    logic                   cs_n_sync;
    logic                   cs_n_last;
    logic                   cs_fall;
    logic                   rd_nwr_meta;
    logic                   rd_nwr_sync;
    logic                   bytesel_meta;
    logic                   bytesel_sync;
    xm_types_pkg::reg_num_t reg_num_meta;
    xm_types_pkg::reg_num_t reg_num_sync;
    xm_types_pkg::byte_t    data_meta;
    xm_types_pkg::byte_t    data_sync;

    assign cs_fall = cs_n_last & ~cs_n_sync;    // select just went active

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_meta      <= 1'b1;    // idle bus, no false edge
            cs_n_sync      <= 1'b1;
            cs_n_last      <= 1'b1;
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
        end else begin
            cs_n_meta      <= bus_cs_n_i;
            cs_n_sync      <= cs_n_meta;
            cs_n_last      <= cs_n_sync;
            write_strobe_o <= cs_fall & ~rd_nwr_sync;
            read_strobe_o  <= cs_fall & rd_nwr_sync;
        end
    end

    // bus fields, stable while chip select is low
    always_ff @(posedge clk) begin
        rd_nwr_meta  <= bus_rd_nwr_i;
        rd_nwr_sync  <= rd_nwr_meta;
        reg_num_meta <= bus_reg_num_i;
        reg_num_sync <= reg_num_meta;
        bytesel_meta <= bus_bytesel_i;
        bytesel_sync <= bytesel_meta;
        data_meta    <= bus_data_i;
        data_sync    <= data_meta;
        if (cs_fall) begin
            reg_num_o <= reg_num_sync;    // held until next access
            bytesel_o <= bytesel_sync;
            byte_o    <= data_sync;
        end
    end

endmodule

`default_nettype wire

// File: hdl/xm_tick_timer.sv
// free-running 1/10 ms timer from a fractional divider, with low byte latch
`default_nettype none

module xm_tick_timer (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               latch_i,        // capture low byte
    output xm_types_pkg::word_t     timer_o,
    output xm_types_pkg::byte_t     latch_low_o
);

    logic [xm_types_pkg::FRAC_BITS-1:0] frac;
    logic                               tick;

    // accumulator non-negative means a tick is due
    assign tick = ~frac[xm_types_pkg::FRAC_BITS-1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac    <= '0;
            timer_o <= '0;
        end else if (tick) begin
            frac    <= frac + xm_types_pkg::FRAC_BITS'(xm_types_pkg::HZ_REDUCED
                                                       - xm_types_pkg::CLK_REDUCED);
            timer_o <= timer_o + 16'd1;
        end else begin
            frac    <= frac + xm_types_pkg::FRAC_BITS'(xm_types_pkg::HZ_REDUCED);
        end
    end

    // high byte read freezes the low byte so both halves match
    always_ff @(posedge clk) begin
        if (reset_i) begin
            latch_low_o <= '0;
        end else if (latch_i) begin
            latch_low_o <= timer_o[7:0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/xm_access_channel.sv
// address, increment and data registers with select/ack requests for one memory
`default_nettype none

module xm_access_channel #(
    parameter bit HAS_INCR = 1'b1          // 0: both addresses step by one
) (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       field_we_i,     // byte write to this channel
    input  wire xm_types_pkg::chan_field_t  field_i,
    input  wire logic                       bytesel_i,
    input  wire xm_types_pkg::byte_t        byte_i,
    input  wire logic                       data_read_i,    // odd byte of data read
    input  wire logic                       ack_i,
    input  wire xm_types_pkg::word_t        mem_data_i,
    output logic                            sel_o,
    output logic                            wr_o,
    output xm_types_pkg::addr_t             addr_o,
    output xm_types_pkg::word_t             data_o,
    output logic                            busy_o,
    output xm_types_pkg::addr_t             rd_addr_o,
    output xm_types_pkg::addr_t             wr_addr_o,
    output xm_types_pkg::word_t             rd_incr_o,
    output xm_types_pkg::word_t             wr_incr_o,
    output xm_types_pkg::word_t             rd_data_o
);

    logic                   rd_pend;        // read waiting for ack
    logic                   step_rd;
    logic                   step_wr;
    xm_types_pkg::byte_t    data_even;      // high byte of next write

    // replace one byte of a word, even byte is the high one
    function automatic xm_types_pkg::word_t put_byte(
        input xm_types_pkg::word_t w,
        input logic                odd,
        input xm_types_pkg::byte_t b
    );
        return odd ? {w[15:8], b} : {b, w[7:0]};
    endfunction

    assign busy_o = sel_o;

    generate
        if (HAS_INCR) begin : g_incr
            always_ff @(posedge clk) begin
                if (reset_i) begin
                    rd_incr_o <= '0;
                    wr_incr_o <= '0;
                end else if (field_we_i) begin
                    if (field_i == xm_types_pkg::RD_INCR) begin
                        rd_incr_o <= put_byte(rd_incr_o, bytesel_i, byte_i);
                    end
                    if (field_i == xm_types_pkg::WR_INCR) begin
                        wr_incr_o <= put_byte(wr_incr_o, bytesel_i, byte_i);
                    end
                end
            end
        end else begin : g_step_one
            assign rd_incr_o = 16'd1;    // fixed stride
            assign wr_incr_o = 16'd1;
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_o     <= 1'b0;
            wr_o      <= 1'b0;
            rd_pend   <= 1'b0;
            step_rd   <= 1'b0;
            step_wr   <= 1'b0;
            rd_addr_o <= '0;
            wr_addr_o <= '0;
            rd_data_o <= '0;
        end else begin
            step_rd <= 1'b0;
            step_wr <= 1'b0;

            if (sel_o && ack_i) begin
                if (rd_pend) begin
                    rd_data_o <= mem_data_i;
                    step_rd   <= 1'b1;
                end
                step_wr <= wr_o;
                sel_o   <= 1'b0;
                wr_o    <= 1'b0;
                rd_pend <= 1'b0;
            end

            // address steps land one clock after the ack
            if (step_rd) begin
                rd_addr_o <= rd_addr_o + rd_incr_o;
            end
            if (step_wr) begin
                wr_addr_o <= wr_addr_o + wr_incr_o;
            end

            if (field_we_i) begin
                case (field_i)
                    xm_types_pkg::RD_ADDR: begin
                        rd_addr_o <= put_byte(rd_addr_o, bytesel_i, byte_i);
                        if (bytesel_i) begin
                            sel_o   <= 1'b1;    // pre-read at new address
                            wr_o    <= 1'b0;
                            rd_pend <= 1'b1;
                            addr_o  <= {rd_addr_o[15:8], byte_i};
                        end
                    end
                    xm_types_pkg::WR_ADDR: begin
                        wr_addr_o <= put_byte(wr_addr_o, bytesel_i, byte_i);
                    end
                    xm_types_pkg::DATA: begin
                        if (bytesel_i) begin
                            sel_o   <= 1'b1;
                            wr_o    <= 1'b1;
                            rd_pend <= 1'b0;
                            addr_o  <= wr_addr_o;
                            data_o  <= {data_even, byte_i};
                        end
                    end
                    default: begin
                    end
                endcase
            end

            if (data_read_i) begin
                sel_o   <= 1'b1;    // fetch next word ahead of the host
                wr_o    <= 1'b0;
                rd_pend <= 1'b1;
                addr_o  <= rd_addr_o;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (field_we_i && field_i == xm_types_pkg::DATA && !bytesel_i) begin
            data_even <= byte_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/xm_reg_interface.sv
// host register window, decodes bus bytes onto VRAM, XR, timer and SYS_CTRL
`default_nettype none

module xm_reg_interface (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_cs_n_i,
    input  wire logic                   bus_rd_nwr_i,
    input  wire xm_types_pkg::reg_num_t bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,
    input  wire xm_types_pkg::byte_t    bus_data_i,
    output xm_types_pkg::byte_t         bus_data_o,
    output logic                        vram_sel_o,
    output logic                        vram_wr_o,
    output xm_types_pkg::addr_t         vram_addr_o,
    output xm_types_pkg::word_t         vram_data_o,
    output logic [3:0]                  vram_wrmask_o,    // nibble write enables
    input  wire logic                   vram_ack_i,
    input  wire xm_types_pkg::word_t    vram_data_i,
    output logic                        xr_sel_o,
    output logic                        xr_wr_o,
    output xm_types_pkg::addr_t         xr_addr_o,
    output xm_types_pkg::word_t         xr_data_o,
    input  wire logic                   xr_ack_i,
    input  wire xm_types_pkg::word_t    xr_data_i,
    input  wire logic                   h_blank_i,
    input  wire logic                   v_blank_i
);

    logic                       write_strobe;
    logic                       read_strobe;
    xm_types_pkg::reg_num_t     reg_num;
    logic                       bytesel;
    xm_types_pkg::byte_t        bus_byte;
    xm_types_pkg::word_t        timer;
    xm_types_pkg::byte_t        timer_low;
    xm_types_pkg::chan_field_t  field;
    logic                       vram_we;
    logic                       xr_we;
    logic                       vram_busy;
    logic                       xr_busy;
    xm_types_pkg::addr_t        vram_rd_addr;
    xm_types_pkg::addr_t        vram_wr_addr;
    xm_types_pkg::word_t        vram_rd_incr;
    xm_types_pkg::word_t        vram_wr_incr;
    xm_types_pkg::word_t        vram_rd_data;
    xm_types_pkg::addr_t        xr_rd_addr;
    xm_types_pkg::addr_t        xr_wr_addr;
    xm_types_pkg::word_t        xr_rd_data;
    xm_types_pkg::word_t        sys_ctrl;
    xm_types_pkg::word_t        rd_word;
    logic                       is_data;

    xm_bus_sync bus_sync_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .write_strobe_o (write_strobe),
        .read_strobe_o  (read_strobe),
        .reg_num_o      (reg_num),
        .bytesel_o      (bytesel),
        .byte_o         (bus_byte)
    );

    // any even byte read refreshes the timer low byte
    xm_tick_timer tick_timer_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .latch_i     (read_strobe & ~bytesel),
        .timer_o     (timer),
        .latch_low_o (timer_low)
    );

    assign is_data = (reg_num == xm_regmap_pkg::XM_DATA) ||
                     (reg_num == xm_regmap_pkg::XM_DATA_2);

    // register number to channel and field
    always_comb begin
        vram_we = 1'b0;
        xr_we   = 1'b0;
        field   = xm_types_pkg::DATA;
        case (reg_num)
            xm_regmap_pkg::XM_RD_XADDR: begin
                xr_we = write_strobe;
                field = xm_types_pkg::RD_ADDR;
            end
            xm_regmap_pkg::XM_WR_XADDR: begin
                xr_we = write_strobe;
                field = xm_types_pkg::WR_ADDR;
            end
            xm_regmap_pkg::XM_XDATA:    xr_we = write_strobe;
            xm_regmap_pkg::XM_RD_INCR: begin
                vram_we = write_strobe;
                field   = xm_types_pkg::RD_INCR;
            end
            xm_regmap_pkg::XM_RD_ADDR: begin
                vram_we = write_strobe;
                field   = xm_types_pkg::RD_ADDR;
            end
            xm_regmap_pkg::XM_WR_INCR: begin
                vram_we = write_strobe;
                field   = xm_types_pkg::WR_INCR;
            end
            xm_regmap_pkg::XM_WR_ADDR: begin
                vram_we = write_strobe;
                field   = xm_types_pkg::WR_ADDR;
            end
            xm_regmap_pkg::XM_DATA,
            xm_regmap_pkg::XM_DATA_2:   vram_we = write_strobe;
            default: begin
            end
        endcase
    end

    xm_access_channel #(.HAS_INCR(1'b1)) vram_chan (
        .clk         (clk),
        .reset_i     (reset_i),
        .field_we_i  (vram_we),
        .field_i     (field),
        .bytesel_i   (bytesel),
        .byte_i      (bus_byte),
        .data_read_i (read_strobe & bytesel & is_data),
        .ack_i       (vram_ack_i),
        .mem_data_i  (vram_data_i),
        .sel_o       (vram_sel_o),
        .wr_o        (vram_wr_o),
        .addr_o      (vram_addr_o),
        .data_o      (vram_data_o),
        .busy_o      (vram_busy),
        .rd_addr_o   (vram_rd_addr),
        .wr_addr_o   (vram_wr_addr),
        .rd_incr_o   (vram_rd_incr),
        .wr_incr_o   (vram_wr_incr),
        .rd_data_o   (vram_rd_data)
    );

    // XR steps by one, increment outputs left open
    xm_access_channel #(.HAS_INCR(1'b0)) xr_chan (
        .clk         (clk),
        .reset_i     (reset_i),
        .field_we_i  (xr_we),
        .field_i     (field),
        .bytesel_i   (bytesel),
        .byte_i      (bus_byte),
        .data_read_i (read_strobe & bytesel & (reg_num == xm_regmap_pkg::XM_XDATA)),
        .ack_i       (xr_ack_i),
        .mem_data_i  (xr_data_i),
        .sel_o       (xr_sel_o),
        .wr_o        (xr_wr_o),
        .addr_o      (xr_addr_o),
        .data_o      (xr_data_o),
        .busy_o      (xr_busy),
        .rd_addr_o   (xr_rd_addr),
        .wr_addr_o   (xr_wr_addr),
        .rd_incr_o   (),
        .wr_incr_o   (),
        .rd_data_o   (xr_rd_data)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_wrmask_o <= xm_regmap_pkg::WRMASK_RESET;
        end else if (write_strobe && bytesel && reg_num == xm_regmap_pkg::XM_SYS_CTRL) begin
            vram_wrmask_o <= bus_byte[3:0];
        end
    end

    always_comb begin
        sys_ctrl                                  = '0;
        sys_ctrl[xm_regmap_pkg::SYS_MEM_WAIT_BIT] = vram_busy | xr_busy;
        sys_ctrl[xm_regmap_pkg::SYS_HBLANK_BIT]   = h_blank_i;
        sys_ctrl[xm_regmap_pkg::SYS_VBLANK_BIT]   = v_blank_i;
        sys_ctrl[3:0]                             = vram_wrmask_o;
    end

    // read mux, unlisted registers read zero
    always_comb begin
        case (reg_num)
            xm_regmap_pkg::XM_SYS_CTRL: rd_word = sys_ctrl;
            xm_regmap_pkg::XM_TIMER:    rd_word = {timer[15:8], timer_low};
            xm_regmap_pkg::XM_RD_XADDR: rd_word = xr_rd_addr;
            xm_regmap_pkg::XM_WR_XADDR: rd_word = xr_wr_addr;
            xm_regmap_pkg::XM_XDATA:    rd_word = xr_rd_data;
            xm_regmap_pkg::XM_RD_INCR:  rd_word = vram_rd_incr;
            xm_regmap_pkg::XM_RD_ADDR:  rd_word = vram_rd_addr;
            xm_regmap_pkg::XM_WR_INCR:  rd_word = vram_wr_incr;
            xm_regmap_pkg::XM_WR_ADDR:  rd_word = vram_wr_addr;
            xm_regmap_pkg::XM_DATA,
            xm_regmap_pkg::XM_DATA_2:   rd_word = vram_rd_data;
            default:                    rd_word = '0;
        endcase
    end

    assign bus_data_o = bytesel ? rd_word[7:0] : rd_word[15:8];    // even byte is high

endmodule

`default_nettype wire

// File: verification/xm_reg_interface_tb.sv
// testbench for the host register window that plays bus operations from a golden file
`default_nettype none

module xm_reg_interface_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk;
    logic                   reset_i;
    logic                   bus_cs_n_i;
    logic                   bus_rd_nwr_i;
    xm_types_pkg::reg_num_t bus_reg_num_i;
    logic                   bus_bytesel_i;
    xm_types_pkg::byte_t    bus_data_i;
    xm_types_pkg::byte_t    bus_data_o;
    logic                   vram_sel_o;
    logic                   vram_wr_o;
    xm_types_pkg::addr_t    vram_addr_o;
    xm_types_pkg::word_t    vram_data_o;
    logic [3:0]             vram_wrmask_o;
    logic                   vram_ack_i;
    xm_types_pkg::word_t    vram_data_i;
    logic                   xr_sel_o;
    logic                   xr_wr_o;
    xm_types_pkg::addr_t    xr_addr_o;
    xm_types_pkg::word_t    xr_data_o;
    logic                   xr_ack_i;
    xm_types_pkg::word_t    xr_data_i;
    logic                   h_blank_i;
    logic                   v_blank_i;

    xm_types_pkg::word_t    vram_mem [0:65535];
    xm_types_pkg::word_t    xr_mem [0:65535];
    logic                   vram_hold;     // stalls the VRAM ack
    int                     vram_wait;
    int                     xr_wait;
    logic [31:0]            lcg_state = 32'h968c;

    xm_reg_interface xm_reg_interface_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic step_clk();
        @(posedge clk);
        #1;    // inputs change just after the edge
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic require_fields(input int found, input int needed, input logic [7:0] kind);
        if (found != needed) begin
            abort_run($sformatf("golden line '%c' has %0d fields where %0d are needed",
                                kind, found, needed));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run("flag compare failed");
        end
    endtask

    task automatic check_byte(input string name, input xm_types_pkg::byte_t got,
                              input xm_types_pkg::byte_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run("byte compare failed");
        end
    endtask

    task automatic check_word(input string name, input xm_types_pkg::word_t got,
                              input xm_types_pkg::word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run("word compare failed");
        end
    endtask

    task automatic check_mask(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: vram_wrmask_o got %h expected %h", $time, got, exp);
            abort_run("write mask compare failed");
        end
    endtask

    task automatic bus_write(input xm_types_pkg::reg_num_t num, input logic sel,
                             input xm_types_pkg::byte_t data);
        bus_cs_n_i    = 1'b0;
        bus_rd_nwr_i  = 1'b0;
        bus_reg_num_i = num;
        bus_bytesel_i = sel;
        bus_data_i    = data;
        repeat (5) step_clk();
        bus_cs_n_i = 1'b1;
        repeat (5) step_clk();
    endtask

    task automatic bus_read(input xm_types_pkg::reg_num_t num, input logic sel,
                            output xm_types_pkg::byte_t data);
        bus_cs_n_i    = 1'b0;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = num;
        bus_bytesel_i = sel;
        repeat (4) step_clk();
        data = bus_data_o;    // valid from the third clock on
        step_clk();
        bus_cs_n_i = 1'b1;
        repeat (5) step_clk();
    endtask

    // memory wait sits in the top bit of the SYS_CTRL high byte
    task automatic poll_idle();
        xm_types_pkg::byte_t status;
        int                  tries;
        tries = 0;
        do begin
            bus_read(xm_regmap_pkg::XM_SYS_CTRL, 1'b0, status);
            tries++;
        end while (status[xm_regmap_pkg::SYS_MEM_WAIT_BIT - 8] && tries < 64);
        if (status[xm_regmap_pkg::SYS_MEM_WAIT_BIT - 8]) begin
            abort_run("memory wait still set after 64 polls of SYS_CTRL");
        end
    endtask

    task automatic check_timer(input int wait_clks);
        xm_types_pkg::byte_t hi;
        xm_types_pkg::byte_t lo;
        xm_types_pkg::word_t first;
        xm_types_pkg::word_t second;
        int                  ticks;
        bus_read(xm_regmap_pkg::XM_TIMER, 1'b0, hi);
        bus_read(xm_regmap_pkg::XM_TIMER, 1'b1, lo);
        first = {hi, lo};
        repeat (wait_clks) step_clk();
        bus_read(xm_regmap_pkg::XM_TIMER, 1'b0, hi);
        bus_read(xm_regmap_pkg::XM_TIMER, 1'b1, lo);
        second = {hi, lo};
        ticks  = wait_clks * xm_types_pkg::HZ_REDUCED / xm_types_pkg::CLK_REDUCED;
        if (second < first || int'(second - first) < ticks - 1 ||
            int'(second - first) > ticks + 2) begin
            abort_run($sformatf("timer moved from %h to %h over %0d clocks, expected %0d ticks",
                                first, second, wait_clks, ticks));
        end
    endtask

    // memory models ack after 1 to 4 clocks
    initial begin : mem_models
        for (int i = 0; i < 65536; i++) begin
            vram_mem[i] = xm_types_pkg::word_t'(i) ^ 16'h5a5a;
            xr_mem[i]   = ~xm_types_pkg::word_t'(i);
        end
        vram_ack_i  = 1'b0;
        vram_data_i = '0;
        xr_ack_i    = 1'b0;
        xr_data_i   = '0;
        vram_wait   = 0;
        xr_wait     = 0;
        forever begin
            step_clk();
            if (vram_ack_i) begin
                vram_ack_i = 1'b0;    // single clock ack
            end else if (vram_sel_o && !vram_hold) begin
                if (vram_wait == 0) vram_wait = 1 + (lcg_next() >> 16) % 4;
                vram_wait--;
                if (vram_wait == 0) begin
                    vram_ack_i = 1'b1;
                    if (vram_wr_o) vram_mem[vram_addr_o] = vram_data_o;
                    else vram_data_i = vram_mem[vram_addr_o];
                end
            end
            if (xr_ack_i) begin
                xr_ack_i = 1'b0;
            end else if (xr_sel_o) begin
                if (xr_wait == 0) xr_wait = 1 + (lcg_next() >> 16) % 4;
                xr_wait--;
                if (xr_wait == 0) begin
                    xr_ack_i = 1'b1;
                    if (xr_wr_o) xr_mem[xr_addr_o] = xr_data_o;
                    else xr_data_i = xr_mem[xr_addr_o];
                end
            end
        end
    end

    initial begin : run
        int                  fd;
        int                  code;
        int                  a;
        int                  b;
        int                  c;
        logic [7:0]          op;
        logic [8*160-1:0]    rest;
        xm_types_pkg::byte_t rd_byte;
        xm_types_pkg::word_t got;
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = '0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        h_blank_i     = 1'b0;
        v_blank_i     = 1'b0;
        vram_hold     = 1'b0;
        fd = $fopen("verification/xm_golden.txt", "r");
        if (fd == 0) abort_run("cannot open verification/xm_golden.txt");
        repeat (10) step_clk();
        reset_i = 1'b0;
        step_clk();
        // both memory ports idle out of reset
        check_flag("vram_sel_o", vram_sel_o, 1'b0);
        check_flag("vram_wr_o", vram_wr_o, 1'b0);
        check_flag("xr_sel_o", xr_sel_o, 1'b0);
        check_flag("xr_wr_o", xr_wr_o, 1'b0);
        while ($fscanf(fd, " %c", op) == 1) begin
            case (op)
                "#": code = $fgets(rest, fd);    // comment line
                "W": begin
                    code = $fscanf(fd, " %h %h %h", a, b, c);
                    require_fields(code, 3, op);
                    bus_write(a[3:0], b[0], c[7:0]);
                end
                "R": begin
                    code = $fscanf(fd, " %h %h %h", a, b, c);
                    require_fields(code, 3, op);
                    bus_read(a[3:0], b[0], rd_byte);
                    check_byte($sformatf("bus_data_o (reg %0h byte %0d)", a, b),
                               rd_byte, c[7:0]);
                end
                "P": poll_idle();
                "M": begin
                    code = $fscanf(fd, " %h %h %h", a, b, c);
                    require_fields(code, 3, op);
                    got  = (a == 0) ? vram_mem[b[15:0]] : xr_mem[b[15:0]];
                    check_word($sformatf("%s[%h]", (a == 0) ? "vram_mem" : "xr_mem", b[15:0]),
                               got, c[15:0]);
                end
                "K": begin
                    code = $fscanf(fd, " %h", a);
                    require_fields(code, 1, op);
                    check_mask(vram_wrmask_o, a[3:0]);
                end
                "B": begin
                    code      = $fscanf(fd, " %h %h", a, b);
                    require_fields(code, 2, op);
                    h_blank_i = a[0];
                    v_blank_i = b[0];
                end
                "H": begin
                    code      = $fscanf(fd, " %h", a);
                    require_fields(code, 1, op);
                    vram_hold = a[0];
                end
                "T": begin
                    code = $fscanf(fd, " %h", a);
                    require_fields(code, 1, op);
                    repeat (a) step_clk();
                end
                "C": begin
                    code = $fscanf(fd, " %h", a);
                    require_fields(code, 1, op);
                    check_timer(a);
                end
                default: abort_run($sformatf("unknown operation '%c' in golden file", op));
            endcase
        end
        $fclose(fd);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/xm_golden.txt
# all numbers hex: W reg sel byte | R reg sel expect | P poll | M mem(0 vram, 1 xr) addr expect
# K mask | B hblank vblank | H hold vram ack | T clocks | C clocks between timer reads
# reset state
R 7 0 00
R 7 1 00
R 9 1 00
R 8 1 00
R 3 1 00
R 0 1 0f
K f
# vram writes, WR_INCR 3 from 0x0100
W 8 0 00
W 8 1 03
W 9 0 01
W 9 1 00
W a 0 12
W a 1 34
P
W a 0 56
W a 1 78
P
W b 0 9a
W b 1 bc
P
M 0 0100 1234
M 0 0103 5678
M 0 0106 9abc
R 9 0 01
R 9 1 09
# vram pre-read, RD_INCR 3 from 0x0100
W 6 0 00
W 6 1 03
W 7 0 01
W 7 1 00
P
R a 0 12
R a 1 34
P
R a 0 56
R a 1 78
P
R b 0 9a
R b 1 bc
P
R 7 0 01
R 7 1 0c
# xr writes and reads step by one
W 4 0 00
W 4 1 20
W 5 0 11
W 5 1 22
P
W 5 0 33
W 5 1 44
P
M 1 0020 1122
M 1 0021 3344
R 4 1 22
W 3 0 00
W 3 1 20
P
R 5 0 11
R 5 1 22
P
R 5 0 33
R 5 1 44
P
R 3 1 23
# sys_ctrl mask, blanks and memory wait
W 0 1 05
R 0 1 05
K 5
B 1 1
R 0 0 0c
B 0 0
H 1
W a 0 ab
W a 1 cd
T 10
R 0 0 80
H 0
P
R 0 0 00
W 0 1 0f
K f
# timer over 30000 clocks
C 7530

// File: sources.f
hdl/xm_types_pkg.sv
hdl/xm_regmap_pkg.sv
hdl/xm_bus_sync.sv
hdl/xm_tick_timer.sv
hdl/xm_access_channel.sv
hdl/xm_reg_interface.sv
verification/xm_reg_interface_tb.sv

// File: Bender.yml
package:
  name: xm_reg_interface

sources:
  - hdl/xm_types_pkg.sv
  - hdl/xm_regmap_pkg.sv
  - hdl/xm_bus_sync.sv
  - hdl/xm_tick_timer.sv
  - hdl/xm_access_channel.sv
  - hdl/xm_reg_interface.sv
  - target: simulation
    files:
      - verification/xm_reg_interface_tb.sv
